// File: axis_bcast.f
+incdir+design
design/bcast_pkg.sv
design/bcast_cfg_regs.sv
design/axis_reg_slice.sv
design/axis_distrib.sv
design/lane_scale.sv
design/axis_bcast_top.sv
bench/tb_axis_bcast.sv

// File: Bender.yml
package:
  name: axis_bcast

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/bcast_pkg.sv
      - design/bcast_cfg_regs.sv
      - design/axis_reg_slice.sv
      - design/axis_distrib.sv
      - design/lane_scale.sv
      - design/axis_bcast_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - bench/tb_axis_bcast.sv

// File: bench/tb_axis_bcast.sv
// broadcast hub testbench with random stimulus, per-lane reference queues, checks and timeout

`default_nettype none

`include "bcast_defines.svh"

module tb_axis_bcast;

  import bcast_pkg::*;

  localparam int DRIVE_DELAY    = 10;
  localparam int RESET_CYCLES   = 16;
  // pipe is three stages deep, so this many idle cycles means empty
  localparam int QUIET_CYCLES   = 8;
  // beats per phase
  localparam int BEATS_RESET    = 40;
  localparam int BEATS_BP       = 200;
  localparam int BEATS_GAIN     = 200;
  localparam int BEATS_MASK     = 200;
  localparam int BEATS_OFF      = 60;
  localparam int TOTAL_BEATS    = BEATS_RESET + BEATS_BP + BEATS_GAIN + BEATS_MASK + BEATS_OFF;
  localparam int TIMEOUT_CYCLES = 20 * TOTAL_BEATS;

  logic                                        clk;
  logic                                        rst;
  logic                                        s_valid;
  logic                                        s_ready;
  sample_t                                     s_data;
  cfg_wr_t                                     cfg;
  logic [`BCAST_NUM_LANES-1:0]                 m_valid;
  logic [`BCAST_NUM_LANES-1:0]                 m_ready;
  lane_out_t [`BCAST_NUM_LANES-1:0]            m_data;

  integer     seed;
  int         cycles;
  int         mismatch_count;
  int         fail_count;
  // input handshake seen at the last falling edge
  logic       in_accepted;

  // shadow of the config registers
  lane_mask_t model_mask;
  gain_t      model_gain [`BCAST_NUM_LANES];
  // expected beats per lane in arrival order
  lane_out_t  exp_q [`BCAST_NUM_LANES][$];

  axis_bcast_top u_axis_bcast_top (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .cfg     (cfg),
    .m_valid (m_valid),
    .m_ready (m_ready),
    .m_data  (m_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  //////////////////////////////
  // reference model
  //////////////////////////////

  // multiply and shift by the fraction bits, then clamp to the sample range
  function automatic lane_out_t scale_model(input sample_t s, input gain_t g);
    lane_out_t r;
    longint    prod;
    longint    max_val;
    longint    min_val;
    max_val = (longint'(1) <<< (`BCAST_DATA_W - 1)) - 1;
    min_val = -(longint'(1) <<< (`BCAST_DATA_W - 1));
    prod    = longint'(s.data) * longint'(g);
    prod    = prod >>> `BCAST_GAIN_FRAC;
    r.last  = s.last;
    r.sat   = 1'b0;
    if (prod > max_val) begin
      r.data = max_val[`BCAST_DATA_W-1:0];
      r.sat  = 1'b1;
    end else if (prod < min_val) begin
      r.data = min_val[`BCAST_DATA_W-1:0];
      r.sat  = 1'b1;
    end else begin
      r.data = prod[`BCAST_DATA_W-1:0];
    end
    return r;
  endfunction

  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // random sample with frequent extremes
  function automatic sample_t random_sample();
    sample_t s;
    int      pick;
    pick = $unsigned($random(seed)) % 8;
    case (pick)
      0:       s.data = {1'b0, {(`BCAST_DATA_W-1){1'b1}}};
      1:       s.data = {1'b1, {(`BCAST_DATA_W-1){1'b0}}};
      2:       s.data = '1;
      default: s.data = $random(seed);
    endcase
    s.last = $random(seed) & 1;
    return s;
  endfunction

  //////////////////////////////
  // monitor and checks
  //////////////////////////////

  // everything settles well before the falling edge
  always @(negedge clk) begin
    lane_out_t expected;
    in_accepted = 1'b0;
    if (!rst) begin
      in_accepted = s_valid && s_ready;
      if (in_accepted) begin
        for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
          if (model_mask[n]) begin
            exp_q[n].push_back(scale_model(s_data, model_gain[n]));
          end
        end
      end
      for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
        if (m_valid[n]) begin
          assert (model_mask[n]) else begin
            fail_count++;
            $display("lane %0d asserted valid while disabled", n);
          end
          if (m_ready[n] && model_mask[n]) begin
            assert (exp_q[n].size() != 0) else begin
              fail_count++;
              $display("lane %0d transferred a beat that was never sent", n);
            end
            if (exp_q[n].size() != 0) begin
              expected = exp_q[n].pop_front();
              assert (m_data[n] == expected) else begin
                mismatch_count++;
                $display("Mismatch m_data[%0d]: got %h expected %h", n, m_data[n], expected);
              end
            end
          end
        end
      end
    end
  end

  task automatic report_counts();
    $display("mismatches %0d, other errors %0d", mismatch_count, fail_count);
  endtask

  // watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("run did not finish within %0d cycles, the hub stalled", TIMEOUT_CYCLES);
      report_counts();
      $display("Something failed");
      $finish;
    end
  end

  //////////////////////////////
  // drivers
  //////////////////////////////

  // single-cycle strobe write that also updates the shadow registers
  task automatic write_cfg(input logic [CFG_ADDR_W-1:0] addr, input logic [CFG_DATA_W-1:0] data);
    @(posedge clk);
    #DRIVE_DELAY;
    cfg.strobe = 1'b1;
    cfg.addr   = addr;
    cfg.data   = data;
    if (addr == CFG_ADDR_MASK) begin
      model_mask = data[`BCAST_NUM_LANES-1:0];
    end else if (addr >= 1 && addr <= `BCAST_NUM_LANES) begin
      model_gain[addr-1] = data[`BCAST_GAIN_W-1:0];
    end
    @(posedge clk);
    #DRIVE_DELAY;
    cfg = '0;
  endtask

  // lanes set in hold_low keep ready low the whole phase
  task automatic run_beats(input int beats, input int valid_pct, input int ready_pct,
                           input lane_mask_t hold_low);
    int issued;
    int accepted;
    issued   = 0;
    accepted = 0;
    while (accepted < beats) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (s_valid && in_accepted) begin
        accepted++;
        s_valid = 1'b0;
      end
      if (!s_valid && issued < beats && chance(valid_pct)) begin
        s_data  = random_sample();
        s_valid = 1'b1;
        issued++;
      end
      for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
        m_ready[n] = hold_low[n] ? 1'b0 : chance(ready_pct);
      end
    end
  endtask

  // open every sink and wait until no lane has shown valid for a while
  task automatic drain();
    int quiet;
    m_ready = '1;
    quiet   = 0;
    while (quiet < QUIET_CYCLES) begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (m_valid == '0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial begin
    lane_mask_t mask;
    seed           = 32'ha25b_de54;
    cycles         = 0;
    mismatch_count = 0;
    fail_count     = 0;
    in_accepted    = 1'b0;
    rst            = 1'b1;
    s_valid        = 1'b0;
    s_data         = '0;
    cfg            = '0;
    m_ready        = '0;
    model_mask     = '1;
    for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
      model_gain[n] = gain_t'(1 << `BCAST_GAIN_FRAC);
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // reset state and then unity gain on every lane
    @(negedge clk);
    assert (m_valid == '0) else begin
      mismatch_count++;
      $display("Mismatch m_valid: got %h expected %h", m_valid, lane_mask_t'(0));
    end
    run_beats(BEATS_RESET, 100, 100, '0);
    drain();

    // random back-pressure on all lanes
    run_beats(BEATS_BP, 60, 50, '0);
    drain();

    // zero, maximum and random gains plus a write to an unknown address
    write_cfg(1, 16'h0000);
    write_cfg(2, 16'h0fff);
    write_cfg(3, $random(seed));
    write_cfg(4, $random(seed));
    write_cfg(4'hf, 16'h0000);
    run_beats(BEATS_GAIN, 70, 60, '0);
    drain();

    // partial mask where disabled lanes hold ready low
    mask = $random(seed);
    if (mask == '0 || mask == '1) begin
      mask = 4'b0101;
    end
    write_cfg(CFG_ADDR_MASK, 16'(mask));
    run_beats(BEATS_MASK, 70, 60, ~mask);
    drain();

    // every lane off while input still flows
    write_cfg(CFG_ADDR_MASK, 16'h0000);
    run_beats(BEATS_OFF, 80, 0, '1);
    drain();

    for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
      assert (exp_q[n].size() == 0) else begin
        fail_count++;
        $display("lane %0d still owes %0d beats at the end", n, exp_q[n].size());
      end
    end
    report_counts();
    if (mismatch_count == 0 && fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/axis_bcast_top.sv
// broadcast hub top: input slice, distributor, lane scalers, output slices and config block

`default_nettype none

`include "bcast_defines.svh"

module axis_bcast_top (
  input  logic                                        clk,
  input  logic                                        rst,
  // input stream
  input  logic                                        s_valid,
  output logic                                        s_ready,
  input  bcast_pkg::sample_t                          s_data,
  // config writes
  input  bcast_pkg::cfg_wr_t                          cfg,
  // lane outputs
  output logic [`BCAST_NUM_LANES-1:0]                 m_valid,
  input  logic [`BCAST_NUM_LANES-1:0]                 m_ready,
  output bcast_pkg::lane_out_t [`BCAST_NUM_LANES-1:0] m_data
);

  import bcast_pkg::*;

  //////////////////////////////
  // internal wires
  //////////////////////////////

  // input slice to distributor
  logic    in_valid;
  logic    in_ready;
  sample_t in_data;

  // config to datapath
  lane_mask_t                          lane_mask;
  gain_t [`BCAST_NUM_LANES-1:0]        gain;

  // distributor to scalers and output slices
  logic [`BCAST_NUM_LANES-1:0]         dist_valid;
  logic [`BCAST_NUM_LANES-1:0]         dist_ready;
  sample_t                             dist_data;
  lane_out_t [`BCAST_NUM_LANES-1:0]    scaled;

  //////////////////////////////
  // config and input side
  //////////////////////////////

  bcast_cfg_regs u_cfg_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg       (cfg),
    .lane_mask (lane_mask),
    .gain      (gain)
  );

  axis_reg_slice #(.payload_t(sample_t)) u_in_slice (
    .clk     (clk),
    .rst     (rst),
    .s_valid (s_valid),
    .s_ready (s_ready),
    .s_data  (s_data),
    .m_valid (in_valid),
    .m_ready (in_ready),
    .m_data  (in_data)
  );

  axis_distrib u_distrib (
    .clk       (clk),
    .rst       (rst),
    .lane_mask (lane_mask),
    .s_valid   (in_valid),
    .s_ready   (in_ready),
    .s_data    (in_data),
    .m_valid   (dist_valid),
    .m_ready   (dist_ready),
    .m_data    (dist_data)
  );

  //////////////////////////////
  // per-lane scaler and slice
  //////////////////////////////

  for (genvar n = 0; n < `BCAST_NUM_LANES; n++) begin : g_lane
    // combinational, slice behind it isolates the multiplier
    lane_scale u_scale (
      .sample (dist_data),
      .gain   (gain[n]),
      .result (scaled[n])
    );

    axis_reg_slice #(.payload_t(lane_out_t)) u_out_slice (
      .clk     (clk),
      .rst     (rst),
      .s_valid (dist_valid[n]),
      .s_ready (dist_ready[n]),
      .s_data  (scaled[n]),
      .m_valid (m_valid[n]),
      .m_ready (m_ready[n]),
      .m_data  (m_data[n])
    );
  end

endmodule

`default_nettype wire

// File: design/lane_scale.sv
// per-lane scaler: signed sample times unsigned gain, fraction shift, saturation, last pass-through

`default_nettype none

`include "bcast_defines.svh"

module lane_scale (
  input  bcast_pkg::sample_t   sample,
  input  bcast_pkg::gain_t     gain,
  output bcast_pkg::lane_out_t result
);

  // full product width, sign bit added for the gain
  localparam int PROD_W = `BCAST_DATA_W + `BCAST_GAIN_W + 1;

  // output sample range
  localparam logic signed [PROD_W-1:0] SAT_MAX = (2 ** (`BCAST_DATA_W - 1)) - 1;
  localparam logic signed [PROD_W-1:0] SAT_MIN = -(2 ** (`BCAST_DATA_W - 1));

  //////////////////////////////
  // multiply and shift
  //////////////////////////////

  logic signed [PROD_W-1:0] product;
  logic signed [PROD_W-1:0] scaled;

  always_comb begin
    // gain zero-extended so it stays positive
    product = $signed(sample.data) * $signed({1'b0, gain});
    // arithmetic shift, truncates toward minus infinity
    scaled  = product >>> `BCAST_GAIN_FRAC;
  end

  //////////////////////////////
  // clamp
  //////////////////////////////

  always_comb begin
    result      = '0;
    result.last = sample.last;
    if (scaled > SAT_MAX) begin
      result.data = SAT_MAX[`BCAST_DATA_W-1:0];
      result.sat  = 1'b1;
    end else if (scaled < SAT_MIN) begin
      result.data = SAT_MIN[`BCAST_DATA_W-1:0];
      result.sat  = 1'b1;
    end else begin
      // in range, low bits carry the value
      result.data = scaled[`BCAST_DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: design/axis_distrib.sv
// stream distributor: one beat register broadcast to all enabled lanes with served tracking

`default_nettype none

`include "bcast_defines.svh"

module axis_distrib (
  input  logic                          clk,
  input  logic                          rst,
  // enabled lanes, from config block
  input  bcast_pkg::lane_mask_t         lane_mask,
  // upstream
  input  logic                          s_valid,
  output logic                          s_ready,
  input  bcast_pkg::sample_t            s_data,
  // one valid/ready pair per lane, shared data
  output logic [`BCAST_NUM_LANES-1:0]   m_valid,
  input  logic [`BCAST_NUM_LANES-1:0]   m_ready,
  output bcast_pkg::sample_t            m_data
);

  import bcast_pkg::*;

  //////////////////////////////
  // served tracking
  //////////////////////////////

  // lanes done with the current beat
  // all ones when no beat is held
  lane_mask_t served_q;
  lane_mask_t served_next;
  lane_mask_t lane_xfer;

  // shared beat register
  sample_t data_q;

  logic s_xfer;

  assign lane_xfer = m_valid & m_ready;

  // masked lanes count as served
  assign served_next = served_q | lane_xfer | ~lane_mask;

  // free once the last outstanding lane goes this cycle
  assign s_ready = &served_next;
  assign s_xfer  = s_valid && s_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      // nothing held, every lane idle
      served_q <= '1;
    end else if (s_xfer) begin
      // new beat, only enabled lanes owe a transfer
      served_q <= ~lane_mask;
    end else begin
      served_q <= served_next;
    end
  end

  //////////////////////////////
  // beat register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (s_xfer) begin
      data_q <= s_data;
    end
  end

  //////////////////////////////
  // lane outputs
  //////////////////////////////

  // lane valid while it still owes the beat
  // low out of reset since served_q resets to ones
  assign m_valid = ~served_q;

  // same word to every lane
  assign m_data = data_q;

endmodule

`default_nettype wire

// File: design/axis_reg_slice.sv
// two-entry skid register slice for valid/ready streams, payload type as parameter

`default_nettype none

module axis_reg_slice #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  // upstream
  input  logic     s_valid,
  output logic     s_ready,
  input  payload_t s_data,
  // downstream
  output logic     m_valid,
  input  logic     m_ready,
  output payload_t m_data
);

  //////////////////////////////
  // state
  //////////////////////////////

  // second entry, catches a beat while the output stalls
  logic     skid_valid;
  payload_t skid_data;

  // output register free this cycle
  logic out_load;
  logic s_xfer;

  assign out_load = m_ready || !m_valid;
  assign s_xfer   = s_valid && s_ready;

  // ready comes straight off the skid flop
  assign s_ready = !skid_valid;

  //////////////////////////////
  // control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_load) begin
      // drain skid first, else take the input directly
      m_valid    <= skid_valid || s_valid;
      skid_valid <= 1'b0;
    end else if (s_xfer) begin
      // output stalled, park the beat
      skid_valid <= 1'b1;
    end
  end

  //////////////////////////////
  // payload
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (out_load) begin
      m_data <= skid_valid ? skid_data : s_data;
    end
    if (!out_load && s_xfer) begin
      skid_data <= s_data;
    end
  end

endmodule

`default_nettype wire

// File: design/bcast_cfg_regs.sv
// configuration register block: lane enable mask and per-lane gains, written by strobe

`default_nettype none

`include "bcast_defines.svh"

module bcast_cfg_regs (
  input  logic                                       clk,
  input  logic                                       rst,
  // strobe write port, no back-pressure
  input  bcast_pkg::cfg_wr_t                         cfg,
  // to distributor
  output bcast_pkg::lane_mask_t                      lane_mask,
  // to lane scalers
  output bcast_pkg::gain_t [`BCAST_NUM_LANES-1:0]    gain
);

  import bcast_pkg::*;

  // unity gain after reset
  localparam gain_t GAIN_UNITY = gain_t'(1 << `BCAST_GAIN_FRAC);

  //////////////////////////////
  // address decode
  //////////////////////////////

  logic                        mask_we;
  logic [`BCAST_NUM_LANES-1:0] gain_we;

  // unknown addresses hit neither enable
  always_comb begin
    mask_we = cfg.strobe && (cfg.addr == CFG_ADDR_MASK);
    for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
      // lane n gain sits one above the mask
      gain_we[n] = cfg.strobe && (cfg.addr == CFG_ADDR_W'(n + 1));
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  // mask, all lanes on out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      lane_mask <= '1;
    end else if (mask_we) begin
      // low lane-count bits of the data word
      lane_mask <= cfg.data[`BCAST_NUM_LANES-1:0];
    end
  end

  // per-lane gains, unity out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
        gain[n] <= GAIN_UNITY;
      end
    end else begin
      for (int n = 0; n < `BCAST_NUM_LANES; n++) begin
        if (gain_we[n]) begin
          gain[n] <= cfg.data[`BCAST_GAIN_W-1:0];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/bcast_pkg.sv
// broadcast hub package: sample, lane output, lane mask, gain and config write types

`default_nettype none

`include "bcast_defines.svh"

package bcast_pkg;

  //////////////////////////////
  // stream payloads
  //////////////////////////////

  // input beat, signed sample plus pass-through last
  typedef struct packed {
    logic signed [`BCAST_DATA_W-1:0] data;
    logic                            last;
  } sample_t;

  // scaled lane beat, sat marks a clipped result
  typedef struct packed {
    logic signed [`BCAST_DATA_W-1:0] data;
    logic                            last;
    logic                            sat;
  } lane_out_t;

  //////////////////////////////
  // configuration
  //////////////////////////////

  // one enable bit per lane
  typedef logic [`BCAST_NUM_LANES-1:0] lane_mask_t;

  // unsigned gain, BCAST_GAIN_FRAC fraction bits
  typedef logic [`BCAST_GAIN_W-1:0] gain_t;

  // config write port sizes, wide enough for mask or gain
  localparam int CFG_ADDR_W = 4;
  localparam int CFG_DATA_W = 16;

  // single-cycle write strobe with address and data
  typedef struct packed {
    logic                  strobe;
    logic [CFG_ADDR_W-1:0] addr;
    logic [CFG_DATA_W-1:0] data;
  } cfg_wr_t;

  // enable mask register, lane n gain lives at n + 1
  localparam logic [CFG_ADDR_W-1:0] CFG_ADDR_MASK = '0;

endpackage

`default_nettype wire

// File: design/bcast_defines.svh
// broadcast hub sizing macros: lane count, sample width, gain width and gain fraction bits

`ifndef BCAST_DEFINES_SVH
`define BCAST_DEFINES_SVH

//////////////////////////////
// lane count
//////////////////////////////

// number of output lanes fed by the distributor
`define BCAST_NUM_LANES 4

//////////////////////////////
// sample and gain widths
//////////////////////////////

// signed two's complement sample width
`define BCAST_DATA_W 16

// unsigned gain word width
`define BCAST_GAIN_W 12

// gain fraction bits, so 1 << 8 = 256 is unity
`define BCAST_GAIN_FRAC 8

`endif
